//--- board_io_top.f
design/board_pkg.sv
design/bus_pkg.sv
design/sync_debouncer.sv
design/scan_tick_divider.sv
design/io_regs.sv
design/seven_seg_scanner.sv
design/board_io_top.sv
dv/board_io_chk.sv
dv/board_io_tb.sv

//--- dv/board_io_tb.sv
`timescale 1ns/1ps

module board_io_tb;

    import board_pkg::*;
    import bus_pkg::*;

    localparam int DEBOUNCE_CYCLES = 4;
    localparam int SCAN_DIV_BASE   = 3;
    localparam int SETTLE_CYCLES   = 2 + DEBOUNCE_CYCLES + 1;
    // scan test alone takes about 8 * 3 * (1 + 4 + 16 + 64) cycles, the rest a few hundred.
    localparam int MAX_CYCLES      = 4000;
    localparam bus_req_t REQ_IDLE  = '0;

    logic        clk;
    logic        rst_n;
    sw_t         sw;
    btn_t        btn;
    bus_req_t    bus_req;
    bus_rsp_t    bus_rsp;
    logic [15:0] led;
    seg_t        seg;
    logic [7:0]  an;

    int seed = 32'h829dfdde;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int errs_at_start = 0;
    int cycle_cnt = 0;

    board_io_top #(
        .DEBOUNCE_CYCLES ( DEBOUNCE_CYCLES ),
        .SCAN_DIV_BASE   ( SCAN_DIV_BASE   )
    ) dut_i (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .sw      ( sw      ),
        .btn     ( btn     ),
        .bus_req ( bus_req ),
        .bus_rsp ( bus_rsp ),
        .led     ( led     ),
        .seg     ( seg     ),
        .an      ( an      )
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycle_cnt);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic int total_errors();
        return errors + int'(dut_i.chk_i.fail_cnt);
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        bus_req <= '{valid: 1'b1, write: 1'b1, addr: addr, wdata: data};
        @(posedge clk);
        bus_req <= REQ_IDLE;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        int waited;
        waited = 0;
        @(posedge clk);
        bus_req <= '{valid: 1'b1, write: 1'b0, addr: addr, wdata: 32'h0};
        @(posedge clk);
        bus_req <= REQ_IDLE;
        @(negedge clk);
        while (!bus_rsp.valid && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        if (!bus_rsp.valid) begin
            $display("no read response for address 0x%02h", addr);
            errors++;
        end
        data = bus_rsp.rdata;
    endtask

    task automatic check_reg(input logic [7:0] addr, input logic [31:0] exp,
                             input string name);
        logic [31:0] data;
        read_reg(addr, data);
        expect_equal(name, data, exp);
    endtask

    task automatic finish_test(input string name);
        int errs_now;
        errs_now = total_errors();
        tests_run++;
        if (errs_now == errs_at_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errs_now - errs_at_start);
        end
        errs_at_start = errs_now;
    endtask

    initial begin
        logic [31:0] val;
        sw_t         sw_val;
        btn_t        press;
        btn_t        mask;
        int          period;
        int          limit;
        int          n;
        int          lit_cnt;
        logic [7:0]  seen;
        logic [7:0]  prev_an;

        clk     = 1'b0;
        rst_n   = 1'b0;
        sw      = '0;
        btn     = '0;
        bus_req = REQ_IDLE;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        expect_equal("an", an, 8'hFF);
        expect_equal("led", led, 16'h0);
        expect_equal("bus_rsp.valid", bus_rsp.valid, 1'b0);
        check_reg(ADDR_EVENT, 32'h0, "event");
        finish_test("reset state");

        for (int i = 0; i < 4; i++) begin
            val = $random(seed);
            write_reg(ADDR_LED, val);
            @(negedge clk);
            expect_equal("led", led, val[15:0]);
            check_reg(ADDR_LED, {16'h0, val[15:0]}, "led readback");
        end
        write_reg(8'h18, $random(seed));
        write_reg(8'h02, $random(seed)); // misaligned, also unmapped.
        check_reg(ADDR_LED, {16'h0, val[15:0]}, "led readback");
        check_reg(ADDR_DISPLAY, 32'h0, "display");
        check_reg(ADDR_DISP_CTRL, 32'h0, "display ctrl");
        check_reg(8'h18, 32'h0, "unmapped read");
        finish_test("led write and readback");

        sw_val = sw_t'($random(seed));
        @(posedge clk);
        sw <= sw_val;
        repeat (SETTLE_CYCLES - 2) @(posedge clk); // read_reg adds the last two edges.
        check_reg(ADDR_SWITCH, {16'h0, sw_val}, "switch");
        @(posedge clk);
        sw <= ~sw_val;
        repeat (2) @(posedge clk);
        sw <= sw_val;
        for (int i = 0; i < 4; i++) begin
            check_reg(ADDR_SWITCH, {16'h0, sw_val}, "switch after glitch");
        end
        finish_test("switch debounce");

        press = '0;
        press.up = 1'b1;
        press.center = 1'b1;
        @(posedge clk);
        btn <= press;
        repeat (SETTLE_CYCLES - 2) @(posedge clk);
        check_reg(ADDR_BUTTON, {27'h0, press}, "button");
        check_reg(ADDR_EVENT, {27'h0, press}, "event");
        @(posedge clk);
        btn <= '0;
        repeat (SETTLE_CYCLES - 2) @(posedge clk);
        check_reg(ADDR_BUTTON, 32'h0, "button");
        check_reg(ADDR_EVENT, {27'h0, press}, "event after release");
        mask = '0;
        mask.up = 1'b1;
        write_reg(ADDR_EVENT, {27'h0, mask});
        check_reg(ADDR_EVENT, {27'h0, press & ~mask}, "event after clear");
        mask = '0;
        mask.right = 1'b1;
        @(posedge clk);
        btn <= mask;
        repeat (SETTLE_CYCLES - 1) @(posedge clk); // the flag lags the level by a cycle.
        check_reg(ADDR_EVENT, {27'h0, (press & ~btn_t'(5'b10000)) | mask}, "event");
        write_reg(ADDR_EVENT, 32'h1F);
        check_reg(ADDR_EVENT, 32'h0, "event after clear all");
        finish_test("button levels and events");

        for (int r = 0; r < 4; r++) begin
            period = SCAN_DIV_BASE << (2 * r);
            limit  = 8 * period + 2; // eight ticks, plus the enable write and the sample.
            write_reg(ADDR_DISPLAY, $random(seed));
            write_reg(ADDR_DISP_CTRL, {29'h0, 2'(r), 1'b0});
            write_reg(ADDR_DISP_CTRL, {29'h0, 2'(r), 1'b1});
            seen    = '0;
            lit_cnt = 0;
            prev_an = 8'hFF;
            n       = 0;
            while (seen != 8'hFF && n < limit) begin
                @(negedge clk);
                if (an != prev_an && an != 8'hFF) begin
                    lit_cnt++;
                end
                seen    = seen | ~an;
                prev_an = an;
                n++;
            end
            if (seen != 8'hFF) begin
                $display("rate %0d: only %0d anode activations in %0d cycles", r, lit_cnt, n);
            end
            expect_equal("digits seen", seen, 8'hFF);
            expect_equal("anode activations", lit_cnt, NUM_DIGITS); // one new digit per tick.
        end
        write_reg(ADDR_DISP_CTRL, 32'h0);
        @(posedge clk); // scanner sees the new enable one cycle after the write.
        @(negedge clk);
        expect_equal("an", an, 8'hFF);
        finish_test("display scanning");

        repeat (2) @(posedge clk);
        $display("%0d tests run, %0d with errors, %0d check errors in total",
                 tests_run, tests_failed, total_errors());
        if (total_errors() == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- dv/board_io_chk.sv
`timescale 1ns/1ps

module board_io_chk (
    input logic              clk,
    input logic              rst_n,
    input bus_pkg::bus_req_t bus_req,
    input bus_pkg::bus_rsp_t bus_rsp,
    input logic [15:0]       led,
    input board_pkg::seg_t   seg,
    input logic [7:0]        an,
    input logic [31:0]       disp_digits
);

    import bus_pkg::*;

    int unsigned fail_cnt = 0;
    logic        rd_req;
    logic        led_wr;
    logic [15:0] led_exp_q;

    assign rd_req = bus_req.valid & ~bus_req.write;
    assign led_wr = bus_req.valid & bus_req.write & (bus_req.addr == ADDR_LED);

    // last value written to the led register.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            led_exp_q <= '0;
        end else if (led_wr) begin
            led_exp_q <= bus_req.wdata[15:0];
        end
    end

    // segments a..g as active-high lines, a in the top bit.
    function automatic logic [7:0] hex_segments(input logic [3:0] nibble);
        logic [6:0] lit;
        case (nibble)
            4'h0:    lit = 7'b1111110;
            4'h1:    lit = 7'b0110000;
            4'h2:    lit = 7'b1101101;
            4'h3:    lit = 7'b1111001;
            4'h4:    lit = 7'b0110011;
            4'h5:    lit = 7'b1011011;
            4'h6:    lit = 7'b1011111;
            4'h7:    lit = 7'b1110000;
            4'h8:    lit = 7'b1111111;
            4'h9:    lit = 7'b1111011;
            4'hA:    lit = 7'b1110111;
            4'hB:    lit = 7'b0011111;
            4'hC:    lit = 7'b1001110;
            4'hD:    lit = 7'b0111101;
            4'hE:    lit = 7'b1001111;
            default: lit = 7'b1000111;
        endcase
        return {~lit, 1'b1}; // active low, dp dark.
    endfunction

    rsp_after_read: assert property (@(posedge clk) disable iff (!rst_n)
        rd_req |=> bus_rsp.valid)
        else begin
            $error("read request got no response in the next cycle");
            fail_cnt++;
        end

    no_rsp_otherwise: assert property (@(posedge clk) disable iff (!rst_n)
        !rd_req |=> !bus_rsp.valid)
        else begin
            $error("response valid without a read request one cycle before");
            fail_cnt++;
        end

    one_anode: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(~an))
        else begin
            $error("ERROR an has more than one digit low: 0x%02h", $sampled(an));
            fail_cnt++;
        end

    // the lit digit must show its own nibble.
    for (genvar k = 0; k < 8; k++) begin : g_digit
        seg_match: assert property (@(posedge clk) disable iff (!rst_n)
            !an[k] |-> seg == hex_segments(disp_digits[4*k +: 4]))
            else begin
                $error("ERROR seg on digit %0d: got 0x%02h, expected 0x%02h", k,
                       $sampled(seg), hex_segments($sampled(disp_digits[4*k +: 4])));
                fail_cnt++;
            end
    end

    led_follows_write: assert property (@(posedge clk) disable iff (!rst_n)
        led_wr |=> led == led_exp_q)
        else begin
            $error("ERROR led: got 0x%04h, expected 0x%04h", $sampled(led),
                   $sampled(led_exp_q));
            fail_cnt++;
        end

endmodule

bind board_io_top board_io_chk chk_i (.*);

//--- design/board_io_top.sv
`timescale 1ns/1ps

module board_io_top #(
    parameter int DEBOUNCE_CYCLES = 1_000_000, // 10 ms at 100 MHz.
    parameter int SCAN_DIV_BASE   = 25_000
) (
    input  logic              clk,
    input  logic              rst_n,
    input  board_pkg::sw_t    sw,
    input  board_pkg::btn_t   btn,
    input  bus_pkg::bus_req_t bus_req,
    output bus_pkg::bus_rsp_t bus_rsp,
    output logic [15:0]       led,
    output board_pkg::seg_t   seg,
    output logic [7:0]        an
);

    import board_pkg::*;

    sw_t         sw_clean;
    btn_t        btn_clean;
    logic [31:0] disp_digits;
    logic        disp_en;
    logic [1:0]  scan_rate;
    logic        scan_tick;

    sync_debouncer #(
        .payload_t       ( sw_t            ),
        .DEBOUNCE_CYCLES ( DEBOUNCE_CYCLES )
    ) sw_db_i (
        .clk   ( clk      ),
        .rst_n ( rst_n    ),
        .raw   ( sw       ),
        .clean ( sw_clean )
    );

    sync_debouncer #(
        .payload_t       ( btn_t           ),
        .DEBOUNCE_CYCLES ( DEBOUNCE_CYCLES )
    ) btn_db_i (
        .clk   ( clk       ),
        .rst_n ( rst_n     ),
        .raw   ( btn       ),
        .clean ( btn_clean )
    );

    io_regs io_regs_i (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .bus_req     ( bus_req     ),
        .bus_rsp     ( bus_rsp     ),
        .switches    ( sw_clean    ),
        .buttons     ( btn_clean   ),
        .led         ( led         ),
        .disp_digits ( disp_digits ),
        .disp_en     ( disp_en     ),
        .scan_rate   ( scan_rate   )
    );

    // clock enable for the digit scan, no derived clock.
    scan_tick_divider #(
        .SCAN_DIV_BASE ( SCAN_DIV_BASE )
    ) scan_div_i (
        .clk    ( clk       ),
        .rst_n  ( rst_n     ),
        .enable ( disp_en   ),
        .rate   ( scan_rate ),
        .tick   ( scan_tick )
    );

    seven_seg_scanner scanner_i (
        .clk    ( clk         ),
        .rst_n  ( rst_n       ),
        .enable ( disp_en     ),
        .tick   ( scan_tick   ),
        .digits ( disp_digits ),
        .seg    ( seg         ),
        .an     ( an          )
    );

endmodule

//--- design/seven_seg_scanner.sv
`timescale 1ns/1ps

module seven_seg_scanner (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            enable,
    input  logic            tick,
    input  logic [31:0]     digits,
    output board_pkg::seg_t seg,
    output logic [7:0]      an
);

    import board_pkg::*;

    logic [2:0] idx_q;
    logic [2:0] idx_next;
    logic [3:0] nibble;

    assign idx_next = idx_q + 3'd1; // wraps from 7 to 0.

    // anodes are active low, one digit lit at a time.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_q <= '0;
            an    <= '1;
        end else if (!enable) begin
            an <= '1;
        end else if (tick) begin
            idx_q <= idx_next;
            an    <= ~(NUM_DIGITS'(1) << idx_next);
        end
    end

    assign nibble = digits[{idx_q, 2'b00} +: 4];

    // segments track the lit digit's nibble.
    always_comb begin
        if (&an) begin
            seg = SEG_BLANK;
        end else begin
            seg = hex_to_seg(nibble);
        end
    end

endmodule

//--- design/io_regs.sv
`timescale 1ns/1ps

module io_regs (
    input  logic              clk,
    input  logic              rst_n,
    input  bus_pkg::bus_req_t bus_req,
    output bus_pkg::bus_rsp_t bus_rsp,
    input  board_pkg::sw_t    switches,
    input  board_pkg::btn_t   buttons,
    output logic [15:0]       led,
    output logic [31:0]       disp_digits,
    output logic              disp_en,
    output logic [1:0]        scan_rate
);

    import bus_pkg::*;
    import board_pkg::*;

    logic                  wr_en;
    logic                  rd_en;
    btn_t                  btn_prev_q;
    logic [BTN_WIDTH-1:0]  evt_q;
    logic [BTN_WIDTH-1:0]  evt_set;
    logic [BTN_WIDTH-1:0]  evt_clr;
    logic [DATA_WIDTH-1:0] rd_mux;
    logic                  rsp_valid_q;
    logic [DATA_WIDTH-1:0] rsp_rdata_q;

    assign wr_en = bus_req.valid & bus_req.write;
    assign rd_en = bus_req.valid & ~bus_req.write;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            led         <= '0;
            disp_digits <= '0;
            disp_en     <= 1'b0;
            scan_rate   <= '0;
        end else if (wr_en) begin
            case (bus_req.addr)
                ADDR_LED: begin
                    led <= bus_req.wdata[15:0]; // upper half is dropped.
                end
                ADDR_DISPLAY: begin
                    disp_digits <= bus_req.wdata;
                end
                ADDR_DISP_CTRL: begin
                    disp_en   <= bus_req.wdata[0];
                    scan_rate <= bus_req.wdata[2:1];
                end
                default: begin
                end
            endcase
        end
    end

    // rising edges of the debounced levels.
    assign evt_set = buttons & ~btn_prev_q;
    assign evt_clr = (wr_en && bus_req.addr == ADDR_EVENT) ?
                     bus_req.wdata[BTN_WIDTH-1:0] : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            btn_prev_q <= '0;
            evt_q      <= '0;
        end else begin
            btn_prev_q <= buttons;
            evt_q      <= (evt_q & ~evt_clr) | evt_set; // set wins.
        end
    end

    always_comb begin
        case (bus_req.addr)
            ADDR_LED:       rd_mux = {16'h0, led};
            ADDR_SWITCH:    rd_mux = {{(DATA_WIDTH - SW_WIDTH){1'b0}}, switches};
            ADDR_BUTTON:    rd_mux = {{(DATA_WIDTH - BTN_WIDTH){1'b0}}, buttons};
            ADDR_EVENT:     rd_mux = {{(DATA_WIDTH - BTN_WIDTH){1'b0}}, evt_q};
            ADDR_DISPLAY:   rd_mux = disp_digits;
            ADDR_DISP_CTRL: rd_mux = {29'h0, scan_rate, disp_en};
            default:        rd_mux = '0;
        endcase
    end

    // read response one cycle after the request.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rsp_rdata_q <= rd_mux;
        end
    end

    assign bus_rsp = '{valid: rsp_valid_q, rdata: rsp_rdata_q};

endmodule

//--- design/scan_tick_divider.sv
`timescale 1ns/1ps

module scan_tick_divider #(
    parameter int SCAN_DIV_BASE = 25_000
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       enable,
    input  logic [1:0] rate,
    output logic       tick
);

    localparam int MAX_PERIOD = SCAN_DIV_BASE << 6;
    localparam int CNT_W      = $clog2(MAX_PERIOD);

    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] term;
    logic [1:0]       rate_q;
    logic             wrap;

    // each rate step stretches the period by four.
    assign term = CNT_W'((SCAN_DIV_BASE << (2 * rate_q)) - 1);
    assign wrap = (cnt_q == term);
    assign tick = enable & wrap;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q  <= '0;
            rate_q <= '0;
        end else if (!enable || wrap) begin
            cnt_q  <= '0;
            rate_q <= rate; // new rate only picked up here.
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

endmodule

//--- design/sync_debouncer.sv
`timescale 1ns/1ps

module sync_debouncer #(
    parameter type payload_t       = logic,
    parameter int  DEBOUNCE_CYCLES = 16     // two or more.
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t raw,
    output payload_t clean
);

    localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

    payload_t         sync_meta_q;
    payload_t         sync_q;
    payload_t         last_q;
    logic [CNT_W-1:0] stable_cnt_q;

    // two-flop synchronizer.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_meta_q <= '0;
            sync_q      <= '0;
        end else begin
            sync_meta_q <= raw;
            sync_q      <= sync_meta_q;
        end
    end

    // stable_cnt_q counts the cycles the synchronized value has held,
    // including the cycle it first appeared.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_q       <= '0;
            stable_cnt_q <= '0;
            clean        <= '0;
        end else if (sync_q != last_q) begin
            last_q       <= sync_q;
            stable_cnt_q <= CNT_W'(1); // restart on any change.
        end else if (stable_cnt_q == CNT_LAST) begin
            clean <= last_q;
        end else begin
            stable_cnt_q <= stable_cnt_q + 1'b1;
        end
    end

endmodule

//--- design/bus_pkg.sv
package bus_pkg;

    localparam int ADDR_WIDTH = 8;
    localparam int DATA_WIDTH = 32;

    // one request per valid cycle, no back-pressure.
    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic                  valid;
        logic [DATA_WIDTH-1:0] rdata;
    } bus_rsp_t;

    // register map.
    localparam logic [ADDR_WIDTH-1:0] ADDR_LED       = 8'h00;
    localparam logic [ADDR_WIDTH-1:0] ADDR_SWITCH    = 8'h04;
    localparam logic [ADDR_WIDTH-1:0] ADDR_BUTTON    = 8'h08;
    localparam logic [ADDR_WIDTH-1:0] ADDR_EVENT     = 8'h0C; // write 1 to clear.
    localparam logic [ADDR_WIDTH-1:0] ADDR_DISPLAY   = 8'h10;
    localparam logic [ADDR_WIDTH-1:0] ADDR_DISP_CTRL = 8'h14;

endpackage

//--- design/board_pkg.sv
package board_pkg;

    localparam int SW_WIDTH   = 16;
    localparam int BTN_WIDTH  = 5;
    localparam int NUM_DIGITS = 8;

    // push buttons in the board's pin order.
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic center;
        logic right;
    } btn_t;

    typedef logic [SW_WIDTH-1:0] sw_t;

    // all segment lines are active low.
    typedef struct packed {
        logic ca;
        logic cb;
        logic cc;
        logic cd;
        logic ce;
        logic cf;
        logic cg;
        logic dp;
    } seg_t;

    localparam seg_t SEG_BLANK = '1;

    function automatic seg_t hex_to_seg(input logic [3:0] nibble);
        seg_t seg;
        case (nibble)
            4'h0:    seg = 8'b0000_0011;
            4'h1:    seg = 8'b1001_1111;
            4'h2:    seg = 8'b0010_0101;
            4'h3:    seg = 8'b0000_1101;
            4'h4:    seg = 8'b1001_1001;
            4'h5:    seg = 8'b0100_1001;
            4'h6:    seg = 8'b0100_0001;
            4'h7:    seg = 8'b0001_1111;
            4'h8:    seg = 8'b0000_0001;
            4'h9:    seg = 8'b0000_1001;
            4'hA:    seg = 8'b0001_0001;
            4'hB:    seg = 8'b1100_0001;
            4'hC:    seg = 8'b0110_0011;
            4'hD:    seg = 8'b1000_0101;
            4'hE:    seg = 8'b0110_0001;
            default: seg = 8'b0111_0001; // F.
        endcase
        return seg;
    endfunction

endpackage
